// File: rtl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// register byte addresses
	localparam logic [7:0] REG_NBY  = 8'h00;
	localparam logic [7:0] REG_ADR  = 8'h04;
	localparam logic [7:0] REG_RDR0 = 8'h08; // four byte lanes, lsb first
	localparam logic [7:0] REG_TDR0 = 8'h0C; // four byte lanes, lsb first
	localparam logic [7:0] REG_CFG  = 8'h10;

	// bits of the config register
	localparam int CFG_WR_START = 0;
	localparam int CFG_WR_DONE  = 1;
	localparam int CFG_RD_START = 2;
	localparam int CFG_RD_DONE  = 3;

	// bus speed, clk_i cycles per quarter of an scl bit
	localparam int QUARTER_DIV = 5;
	localparam int QDIV_W      = $clog2(QUARTER_DIV);

	typedef enum logic [3:0] {
		IDLE,
		START,
		ADDR,
		ADDR_ACK,
		WDATA,
		WACK,
		RDATA,
		RACK,
		STOP
	} i2c_state_e;

endpackage

`default_nettype wire

// File: rtl/i2c_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_apb_regs import i2c_pkg::*; (
	input  logic        clk_i,
	input  logic        rst,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [7:0]  paddr_i,
	input  logic [7:0]  pwdata_i,
	output logic [7:0]  prdata_o,
	output logic        pready_o,
	input  logic        busy_i,
	input  logic        done_i,
	input  logic        nack_i,
	input  logic        rdr_wr_i,
	input  logic [1:0]  rdr_byte_i,
	input  logic [7:0]  rdr_data_i,
	output logic        start_o,
	output logic        read_o,
	output logic [1:0]  nby_o,
	output logic [6:0]  adr_o,
	output logic [31:0] tdr_o
);

	logic        setup;
	logic        one_start;
	logic [31:0] rdr_q;
	logic [3:0]  cfg_q;
	logic        nack_q;

	assign setup = psel_i & ~penable_i; // apb setup phase
	assign one_start = pwdata_i[CFG_WR_START] ^ pwdata_i[CFG_RD_START];

	always_ff @(posedge clk_i) begin
		if (rst) begin
			prdata_o <= 8'h00;
			pready_o <= 1'b0;
			start_o  <= 1'b0;
			read_o   <= 1'b0;
			nby_o    <= 2'd0;
			adr_o    <= 7'd0;
			tdr_o    <= 32'd0;
			rdr_q    <= 32'd0;
			cfg_q    <= 4'd0;
			nack_q   <= 1'b0;
		end else begin
			pready_o <= setup; // access phase follows setup
			start_o  <= 1'b0;

			if (setup && pwrite_i) begin
				case (paddr_i)
					REG_NBY: nby_o <= (pwdata_i[7:2] == 6'd0) ? pwdata_i[1:0] : 2'd0;
					REG_ADR: adr_o <= pwdata_i[6:0];
					REG_CFG: begin
						if (!busy_i) begin
							cfg_q <= 4'd0; // clears the done bits
							cfg_q[CFG_WR_START] <= pwdata_i[CFG_WR_START];
							cfg_q[CFG_RD_START] <= pwdata_i[CFG_RD_START];
							if (nby_o != 2'd0 && one_start) begin
								start_o <= 1'b1;
								read_o  <= pwdata_i[CFG_RD_START];
							end
						end
					end
					default: begin
						if (paddr_i[7:2] == REG_TDR0[7:2])
							tdr_o[{paddr_i[1:0], 3'b000} +: 8] <= pwdata_i;
					end
				endcase
			end

			if (setup && !pwrite_i) begin
				case (paddr_i)
					REG_NBY: prdata_o <= {4'h0, nack_q, 1'b0, nby_o};
					REG_ADR: prdata_o <= {1'b0, adr_o};
					REG_CFG: prdata_o <= {4'h0, cfg_q};
					default: begin
						if (paddr_i[7:2] == REG_RDR0[7:2])
							prdata_o <= rdr_q[{paddr_i[1:0], 3'b000} +: 8];
						else if (paddr_i[7:2] == REG_TDR0[7:2])
							prdata_o <= tdr_o[{paddr_i[1:0], 3'b000} +: 8];
						else
							prdata_o <= 8'h00; // unmapped
					end
				endcase
			end

			if (rdr_wr_i)
				rdr_q[{rdr_byte_i, 3'b000} +: 8] <= rdr_data_i;

			// completion from the bus side
			if (done_i) begin
				cfg_q[CFG_WR_START] <= 1'b0;
				cfg_q[CFG_RD_START] <= 1'b0;
				cfg_q[read_o ? CFG_RD_DONE : CFG_WR_DONE] <= 1'b1;
				nack_q <= nack_i;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/i2c_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_timer import i2c_pkg::*; (
	input  logic       clk_i,
	input  logic       rst,
	input  logic       run_i,
	output logic       tick_o,
	output logic [1:0] phase_o
);

	logic [QDIV_W-1:0] pre_cnt;

	// last cycle of the current quarter
	assign tick_o = run_i & (pre_cnt == QDIV_W'(QUARTER_DIV - 1));

	always_ff @(posedge clk_i) begin
		if (rst || !run_i) begin
			pre_cnt <= '0; // held so a new run starts at phase 0
			phase_o <= 2'd0;
		end else if (tick_o) begin
			pre_cnt <= '0;
			phase_o <= phase_o + 2'd1; // wraps 3 -> 0 at bit end
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/i2c_xfer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_xfer_fsm import i2c_pkg::*; (
	input  logic        clk_i,
	input  logic        rst,
	input  logic        start_i,
	input  logic        read_i,
	input  logic [1:0]  nby_i,
	input  logic [6:0]  adr_i,
	input  logic [31:0] tdr_i,
	input  logic        tick_i,
	input  logic [1:0]  phase_i,
	input  logic        sda_i,
	output logic        run_o,
	output logic        busy_o,
	output logic        done_o,
	output logic        nack_o,
	output logic        rdr_wr_o,
	output logic [1:0]  rdr_byte_o,
	output logic [7:0]  rdr_data_o,
	output logic        scl_low_o,
	output logic        sda_low_o
);

	i2c_state_e state;
	logic [7:0] sh;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [1:0] nby_q;
	logic       rd_q;
	logic       nack_q;
	logic       bit_end;
	logic       sample;
	logic       last_byte;
	logic       scl_gap;

	assign bit_end   = tick_i & (phase_i == 2'd3);
	assign sample    = tick_i & (phase_i == 2'd1); // scl high, entering phase 2
	assign last_byte = (byte_cnt == nby_q - 2'd1);
	assign scl_gap   = (phase_i == 2'd0) || (phase_i == 2'd3);

	always_ff @(posedge clk_i) begin
		if (rst) begin
			state    <= IDLE;
			rd_q     <= 1'b0;
			nby_q    <= 2'd0;
			nack_q   <= 1'b0;
			bit_cnt  <= 3'd0;
			byte_cnt <= 2'd0;
		end else begin
			case (state)
				IDLE: begin
					if (start_i) begin
						state  <= START;
						rd_q   <= read_i;
						nby_q  <= nby_i;
						nack_q <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						state   <= ADDR;
						sh      <= {adr_i, rd_q};
						bit_cnt <= 3'd7;
					end
				end
				ADDR, WDATA: begin
					if (bit_end) begin
						sh      <= {sh[6:0], 1'b0}; // msb first
						bit_cnt <= bit_cnt - 3'd1;
						if (bit_cnt == 3'd0 && state == ADDR)
							state <= ADDR_ACK;
						else if (bit_cnt == 3'd0)
							state <= WACK;
					end
				end
				ADDR_ACK: begin
					if (sample)
						nack_q <= sda_i;
					if (bit_end) begin
						byte_cnt <= 2'd0;
						bit_cnt  <= 3'd7;
						sh       <= tdr_i[7:0];
						if (nack_q)
							state <= STOP; // nobody answered
						else if (rd_q)
							state <= RDATA;
						else
							state <= WDATA;
					end
				end
				WACK: begin
					if (bit_end) begin
						if (last_byte) begin
							state <= STOP;
						end else begin
							state    <= WDATA;
							byte_cnt <= byte_cnt + 2'd1;
							sh       <= tdr_i[{byte_cnt + 2'd1, 3'b000} +: 8];
						end
					end
				end
				RDATA: begin
					if (sample)
						sh <= {sh[6:0], sda_i};
					if (bit_end) begin
						bit_cnt <= bit_cnt - 3'd1;
						if (bit_cnt == 3'd0)
							state <= RACK;
					end
				end
				RACK: begin
					if (bit_end) begin
						if (last_byte) begin
							state <= STOP;
						end else begin
							state    <= RDATA;
							byte_cnt <= byte_cnt + 2'd1;
						end
					end
				end
				STOP: begin
					if (bit_end)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign busy_o     = (state != IDLE);
	assign run_o      = busy_o;
	assign done_o     = bit_end & (state == STOP);
	assign nack_o     = nack_q;
	assign rdr_wr_o   = bit_end & (state == RDATA) & (bit_cnt == 3'd0);
	assign rdr_byte_o = byte_cnt;
	assign rdr_data_o = sh;

	// open-drain levels per quarter
	always_comb begin
		scl_low_o = busy_o & scl_gap;
		sda_low_o = 1'b0;
		case (state)
			START: sda_low_o = phase_i[1]; // falls while scl high
			ADDR, WDATA: sda_low_o = ~sh[7];
			RACK: sda_low_o = ~last_byte; // nack ends the read
			STOP: begin
				scl_low_o = (phase_i == 2'd0);
				sda_low_o = ~phase_i[1]; // rises while scl high
			end
			default: sda_low_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/i2c_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top (
	input  logic       clk_i,
	input  logic       rst,
	input  logic       psel_i,
	input  logic       penable_i,
	input  logic       pwrite_i,
	input  logic [7:0] paddr_i,
	input  logic [7:0] pwdata_i,
	output logic [7:0] prdata_o,
	output logic       pready_o,
	inout  wire        scl_io,
	inout  wire        sda_io
);

	logic        start;
	logic        rd_dir;
	logic [1:0]  nby;
	logic [6:0]  adr;
	logic [31:0] tdr;
	logic        busy;
	logic        done;
	logic        nack;
	logic        rdr_wr;
	logic [1:0]  rdr_byte;
	logic [7:0]  rdr_data;
	logic        run;
	logic        tick;
	logic [1:0]  phase;
	logic        scl_low;
	logic        sda_low;
	logic        sda_in;

	assign scl_io = scl_low ? 1'b0 : 1'bz; // released lines float to the pull-up
	assign sda_io = sda_low ? 1'b0 : 1'bz;
	assign sda_in = sda_io;

	i2c_apb_regs u_regs (
		.clk_i      (clk_i),
		.rst        (rst),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.prdata_o   (prdata_o),
		.pready_o   (pready_o),
		.busy_i     (busy),
		.done_i     (done),
		.nack_i     (nack),
		.rdr_wr_i   (rdr_wr),
		.rdr_byte_i (rdr_byte),
		.rdr_data_i (rdr_data),
		.start_o    (start),
		.read_o     (rd_dir),
		.nby_o      (nby),
		.adr_o      (adr),
		.tdr_o      (tdr)
	);

	i2c_xfer_fsm u_fsm (
		.clk_i      (clk_i),
		.rst        (rst),
		.start_i    (start),
		.read_i     (rd_dir),
		.nby_i      (nby),
		.adr_i      (adr),
		.tdr_i      (tdr),
		.tick_i     (tick),
		.phase_i    (phase),
		.sda_i      (sda_in),
		.run_o      (run),
		.busy_o     (busy),
		.done_o     (done),
		.nack_o     (nack),
		.rdr_wr_o   (rdr_wr),
		.rdr_byte_o (rdr_byte),
		.rdr_data_o (rdr_data),
		.scl_low_o  (scl_low),
		.sda_low_o  (sda_low)
	);

	i2c_bit_timer u_timer (
		.clk_i   (clk_i),
		.rst     (rst),
		.run_i   (run),
		.tick_o  (tick),
		.phase_o (phase)
	);

endmodule

`default_nettype wire

// File: sim/i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] OWN_ADR = 7'h2a
) (
	input  wire         clk_i,
	input  wire         rst,
	input  wire  [31:0] rd_bytes_i,
	output logic [31:0] log_o,
	output logic [2:0]  log_cnt_o,
	inout  wire         scl_io,
	inout  wire         sda_io
);

	typedef enum logic [2:0] {S_IDLE, S_RECV, S_ACK, S_SEND, S_MACK} slave_state_e;

	slave_state_e st;
	logic       scl_q;
	logic       sda_q;
	logic       drive_low;
	logic [7:0] sh;
	logic [3:0] bit_cnt;
	logic       is_addr;
	logic       rw;
	logic [1:0] byte_idx;
	logic       mack;

	pullup (scl_io);
	pullup (sda_io);
	assign sda_io = drive_low ? 1'b0 : 1'bz;

	// bus is oversampled on the falling clock edge, clear of the master's updates
	always @(negedge clk_i) begin
		if (rst) begin
			st        <= S_IDLE;
			drive_low <= 1'b0;
			scl_q     <= 1'b1;
			sda_q     <= 1'b1;
			bit_cnt   <= 4'd0;
			is_addr   <= 1'b0;
			rw        <= 1'b0;
			mack      <= 1'b0;
			log_o     <= 32'd0;
			log_cnt_o <= 3'd0;
		end else begin
			scl_q <= scl_io;
			sda_q <= sda_io;
			if (scl_io && scl_q && sda_q && !sda_io) begin // start
				st        <= S_RECV;
				is_addr   <= 1'b1;
				bit_cnt   <= 4'd0;
				log_cnt_o <= 3'd0;
				drive_low <= 1'b0;
			end else if (scl_io && scl_q && !sda_q && sda_io) begin // stop
				st        <= S_IDLE;
				drive_low <= 1'b0;
			end else if (scl_io && !scl_q) begin // scl rising
				if (st == S_RECV) begin
					sh      <= {sh[6:0], sda_io};
					bit_cnt <= bit_cnt + 4'd1;
				end
				if (st == S_MACK)
					mack <= !sda_io;
			end else if (!scl_io && scl_q) begin // scl falling
				case (st)
					S_RECV: begin
						if (bit_cnt == 4'd8 && (!is_addr || sh[7:1] == OWN_ADR)) begin
							if (log_cnt_o < 3'd4) begin
								log_o[{log_cnt_o[1:0], 3'b000} +: 8] <= sh;
								log_cnt_o <= log_cnt_o + 3'd1;
							end
							if (is_addr)
								rw <= sh[0];
							drive_low <= 1'b1; // ack
							st        <= S_ACK;
						end else if (bit_cnt == 4'd8) begin
							st <= S_IDLE; // not our address
						end
					end
					S_ACK: begin
						is_addr <= 1'b0;
						bit_cnt <= 4'd0;
						if (rw) begin
							byte_idx  <= 2'd0;
							sh        <= rd_bytes_i[7:0];
							drive_low <= ~rd_bytes_i[7];
							st        <= S_SEND;
						end else begin
							drive_low <= 1'b0;
							st        <= S_RECV;
						end
					end
					S_SEND: begin
						bit_cnt <= bit_cnt + 4'd1;
						sh      <= {sh[6:0], 1'b0};
						if (bit_cnt == 4'd7) begin
							drive_low <= 1'b0; // master acks now
							st        <= S_MACK;
						end else begin
							drive_low <= ~sh[6];
						end
					end
					S_MACK: begin
						if (mack) begin
							byte_idx  <= byte_idx + 2'd1;
							bit_cnt   <= 4'd0;
							sh        <= rd_bytes_i[{byte_idx + 2'd1, 3'b000} +: 8];
							drive_low <= ~rd_bytes_i[{byte_idx + 2'd1, 3'b111}];
							st        <= S_SEND;
						end else begin
							st <= S_IDLE;
						end
					end
					default: st <= S_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

	localparam logic [6:0] SLAVE_ADR = 7'h2a;
	localparam int BIT_CYCLES = 4 * QUARTER_DIV;

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [7:0]  pwdata;
	wire  [7:0]  prdata;
	wire         pready;
	wire         scl;
	wire         sda;
	logic [31:0] slave_rd;
	wire  [31:0] slave_log;
	wire  [2:0]  slave_log_cnt;
	logic [31:0] seed;
	int          errors;
	int          test_errors;
	int          tests_run;

	i2c_master_top UUT (
		.clk_i     (clk),
		.rst       (rst),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.scl_io    (scl),
		.sda_io    (sda)
	);

	i2c_slave_model #(.OWN_ADR(SLAVE_ADR)) u_slave (
		.clk_i      (clk),
		.rst        (rst),
		.rd_bytes_i (slave_rd),
		.log_o      (slave_log),
		.log_cnt_o  (slave_log_cnt),
		.scl_io     (scl),
		.sda_io     (sda)
	);

	always #5 clk = ~clk;

	function automatic logic [7:0] lcg_byte();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16]; // upper bits have the longer period
	endfunction

	function automatic logic [31:0] lcg_word();
		return {lcg_byte(), lcg_byte(), lcg_byte(), lcg_byte()};
	endfunction

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready && waited < 8) begin
			@(posedge clk);
			waited++;
		end
		if (!pready) begin
			$display("APB access to 0x%0h never got pready", addr);
			test_errors++;
		end
		rdata = prdata;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
		logic [7:0] ignored;
		apb_access(1'b1, addr, data, ignored);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
		apb_access(1'b0, addr, 8'h00, data);
	endtask

	task automatic expect_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", sig, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_errors;
		$display("test %0d %s: %s, %0d error(s)", tests_run, name,
			(test_errors == 0) ? "passed" : "failed", test_errors);
		test_errors = 0;
	endtask

	task automatic start_xfer(input logic [6:0] adr, input int nby, input logic [31:0] tdr,
		input logic rd);
		apb_write(REG_ADR, {1'b0, adr});
		apb_write(REG_NBY, 8'(nby));
		for (int i = 0; i < 4; i++)
			apb_write(REG_TDR0 + 8'(i), tdr[8*i +: 8]);
		apb_write(REG_CFG, rd ? 8'(1 << CFG_RD_START) : 8'(1 << CFG_WR_START));
	endtask

	// start, address byte, data bytes with acks, stop
	task automatic wait_done(input int nby);
		int limit;
		int waited;
		logic [7:0] cfg;
		limit = 2 * (2 + 9 * (1 + nby)) * BIT_CYCLES;
		waited = 0;
		cfg = 8'h00;
		while (!(cfg[CFG_WR_DONE] | cfg[CFG_RD_DONE]) && waited < limit) begin
			apb_read(REG_CFG, cfg);
			waited += 3;
		end
		if (!(cfg[CFG_WR_DONE] | cfg[CFG_RD_DONE])) begin
			$display("transfer did not finish within %0d cycles", limit);
			test_errors++;
		end
	endtask

	task automatic check_write(input logic [6:0] adr, input int nby, input logic [31:0] tdr);
		logic [7:0] val;
		apb_read(REG_CFG, val);
		expect_val("cfg", val, 1 << CFG_WR_DONE);
		apb_read(REG_NBY, val);
		expect_val("nby", val, nby); // nack flag clear
		expect_val("slave log count", slave_log_cnt, nby + 1);
		expect_val("slave address byte", slave_log[7:0], {adr, 1'b0});
		for (int i = 1; i <= nby; i++)
			expect_val($sformatf("slave data byte %0d", i - 1), slave_log[8*i +: 8],
				tdr[8*(i-1) +: 8]);
		expect_val("scl", scl, 1);
		expect_val("sda", sda, 1);
	endtask

	initial begin
		logic [7:0]  val;
		logic [7:0]  wv;
		logic [31:0] tdr;
		logic [6:0]  adr;
		int          nby;
		clk         = 1'b0;
		rst         = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = 8'h00;
		pwdata      = 8'h00;
		slave_rd    = 32'd0;
		seed        = 32'h24d6;
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		apb_read(REG_NBY, val);
		expect_val("nby", val, 0);
		apb_read(REG_ADR, val);
		expect_val("adr", val, 0);
		apb_read(REG_CFG, val);
		expect_val("cfg", val, 0);
		for (int i = 0; i < 4; i++) begin
			apb_read(REG_RDR0 + 8'(i), val);
			expect_val($sformatf("rdr byte %0d", i), val, 0);
			apb_read(REG_TDR0 + 8'(i), val);
			expect_val($sformatf("tdr byte %0d", i), val, 0);
		end
		expect_val("scl", scl, 1);
		expect_val("sda", sda, 1);
		finish_test("reset values");

		for (int i = 0; i < 4; i++) begin
			adr = 7'(lcg_byte());
			apb_write(REG_ADR, {1'b0, adr});
			apb_read(REG_ADR, val);
			expect_val("adr", val, {1'b0, adr});
		end
		tdr = lcg_word();
		for (int i = 0; i < 4; i++)
			apb_write(REG_TDR0 + 8'(i), tdr[8*i +: 8]);
		for (int i = 0; i < 4; i++) begin
			apb_read(REG_TDR0 + 8'(i), val);
			expect_val($sformatf("tdr byte %0d", i), val, tdr[8*i +: 8]);
		end
		for (int i = 0; i < 10; i++) begin
			wv = (i < 4) ? 8'(i) : lcg_byte(); // small counts first, then random
			apb_write(REG_NBY, wv);
			apb_read(REG_NBY, val);
			expect_val("nby", val, (wv >= 1 && wv <= 3) ? wv : 8'h00);
		end
		finish_test("register access");

		nby = 1 + lcg_byte() % 3;
		tdr = lcg_word();
		start_xfer(SLAVE_ADR, nby, tdr, 1'b0);
		wait_done(nby);
		check_write(SLAVE_ADR, nby, tdr);
		finish_test("write transfer");

		nby = 1 + lcg_byte() % 3;
		slave_rd = lcg_word();
		start_xfer(SLAVE_ADR, nby, tdr, 1'b1);
		wait_done(nby);
		apb_read(REG_CFG, val);
		expect_val("cfg", val, 1 << CFG_RD_DONE);
		apb_read(REG_NBY, val);
		expect_val("nby", val, nby);
		for (int i = 0; i < nby; i++) begin
			apb_read(REG_RDR0 + 8'(i), val);
			expect_val($sformatf("rdr byte %0d", i), val, slave_rd[8*i +: 8]);
		end
		expect_val("slave log count", slave_log_cnt, 1);
		expect_val("slave address byte", slave_log[7:0], {SLAVE_ADR, 1'b1});
		finish_test("read transfer");

		adr = 7'(lcg_byte());
		if (adr == SLAVE_ADR)
			adr = adr ^ 7'h01;
		nby = 1 + lcg_byte() % 3;
		tdr = lcg_word();
		start_xfer(adr, nby, tdr, 1'b0);
		wait_done(nby);
		apb_read(REG_CFG, val);
		expect_val("cfg", val, 1 << CFG_WR_DONE);
		apb_read(REG_NBY, val);
		expect_val("nby", val, (1 << 3) | nby); // nack flag in bit 3
		expect_val("slave log count", slave_log_cnt, 0);
		finish_test("address nack");

		nby = 1 + lcg_byte() % 3;
		tdr = lcg_word();
		start_xfer(SLAVE_ADR, nby, tdr, 1'b0);
		apb_write(REG_CFG, 8'(1 << CFG_RD_START));
		apb_read(REG_CFG, val);
		expect_val("cfg while busy", val, 1 << CFG_WR_START);
		wait_done(nby);
		check_write(SLAVE_ADR, nby, tdr);
		finish_test("cfg write while busy");

		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: i2c_apb.f
rtl/i2c_pkg.sv
rtl/i2c_apb_regs.sv
rtl/i2c_bit_timer.sv
rtl/i2c_xfer_fsm.sv
rtl/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_apb

sources:
  - rtl/i2c_pkg.sv
  - rtl/i2c_apb_regs.sv
  - rtl/i2c_bit_timer.sv
  - rtl/i2c_xfer_fsm.sv
  - rtl/i2c_master_top.sv
  - target: simulation
    files:
      - sim/i2c_slave_model.sv
      - sim/tb_i2c_master.sv
